// ==== Makefile ====
# Verilator build of the I/O fabric testbench

OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module tb_io_subsystem \
		-Mdir $(OBJ_DIR) -o tb_io_subsystem

run: compile
	./$(OBJ_DIR)/tb_io_subsystem | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no pass result in log"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim.f ====
verilog/ioreg_pkg.sv
verilog/avbus_pkg.sv
verilog/ioreg_decode.sv
verilog/gp_reg_bank.sv
verilog/return_stack.sv
verilog/av_master_bridge.sv
verilog/ioreg_readback.sv
verilog/io_subsystem_top.sv
tb/tb_io_subsystem.sv

// ==== tb/io_stimulus.txt ====
// one hex word per line: op_reg_data_keys
// op 1 load, 2 consuming read, 3 peek, 4 pins (anmux nibble, leds byte), 5 slave word
1_00_1234_0
1_07_beef_0
3_00_1234_0
3_07_beef_0
1_11_a55a_0
1_13_00f9_0
3_11_a55a_0
3_13_00f9_0
4_00_095a_0
1_08_dead_0  // gp number beyond GP_COUNT
3_08_0000_0
1_1f_cafe_0  // unmapped
3_1f_0000_0
1_12_ffff_1  // key status is read-only
3_12_0001_1
3_12_0002_2
1_17_1111_0
3_17_0000_0
1_10_0101_0  // three pushes then three pops
1_10_0202_0
1_10_0303_0
2_10_0303_0
2_10_0202_0
2_10_0101_0
3_10_0000_0
1_14_0012_0  // bus address high half
1_15_0042_0
1_16_5a5a_0
5_42_5a5a_0
1_15_0043_0
1_16_c3c3_0
5_43_c3c3_0
1_15_0042_0
2_16_c3c3_0  // read back the first write
3_17_5a5a_0
1_15_0080_0
2_16_c3c3_0  // untouched word shows the fill
3_17_807f_0
3_00_1234_0
0_00_0000_0

// ==== tb/tb_io_subsystem.sv ====
`default_nettype none

module tb_io_subsystem;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int GP_COUNT = 8;
    localparam int STACK_DEPTH = 32;
    // inputs change this long after the rising edge
    localparam int DRIVE_DELAY = 5;
    // combinational readback settle time
    localparam int SETTLE = 2;
    // max cycles to wait for mcu_wait to drop
    localparam int WAIT_LIMIT = 20;
    localparam int STIM_DEPTH = 64;

    logic sysclk;
    logic rst;
    ioreg_pkg::reg_num_t reg_addr;
    ioreg_pkg::word_t reg_wdata;
    logic reg_load;
    logic reg_read;
    ioreg_pkg::word_t reg_rdata;
    logic mcu_wait;
    logic [1:0] keys;
    logic [7:0] leds;
    logic [3:0] anmux_ctrl;
    avbus_pkg::av_addr_t av_address;
    logic av_read;
    logic av_write;
    avbus_pkg::av_data_t av_writedata;
    avbus_pkg::av_data_t av_readdata;
    logic av_waitrequest;

    // op, register, data, keys packed per entry
    logic [31:0] stim [STIM_DEPTH];
    int entry_idx;

    // bus address expected from the last half loads
    ioreg_pkg::word_t exp_ad_hi;
    ioreg_pkg::word_t exp_ad_lo;

    // avalon slave model state
    avbus_pkg::av_data_t slave_mem [256];
    logic [31:0] rng_state;
    int stall_left;
    logic in_txn;
    logic accept_pending;
    logic acc_write;
    logic [7:0] acc_idx;
    avbus_pkg::av_data_t acc_data;

    io_subsystem_top #(.GP_COUNT(GP_COUNT), .STACK_DEPTH(STACK_DEPTH)) u_dut (
        .sysclk(sysclk), .rst(rst), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .reg_load(reg_load), .reg_read(reg_read), .reg_rdata(reg_rdata),
        .mcu_wait(mcu_wait), .keys(keys), .leds(leds), .anmux_ctrl(anmux_ctrl),
        .av_address(av_address), .av_read(av_read), .av_write(av_write),
        .av_writedata(av_writedata), .av_readdata(av_readdata),
        .av_waitrequest(av_waitrequest)
    );

    // 100 ns period
    always #50 sysclk = ~sysclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s = 0x%h, expected 0x%h (entry %0d)", name, got, exp, entry_idx);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("[FAIL] %s = 0x%h, expected 0x%h (entry %0d)", name, got, exp, entry_idx);
            stop_run();
        end
    endtask

    // request address built from the two halves
    task automatic check_bus_address();
        check_value("av_address[31:16]", av_address[31:16], exp_ad_hi);
        check_value("av_address[15:0]", av_address[15:0], exp_ad_lo);
    endtask

    task automatic next_cycle();
        @(posedge sysclk);
        #DRIVE_DELAY;
    endtask

    // mcu_wait marks the end of a bus transaction
    task automatic wait_bus_idle();
        int cycles;
        cycles = 0;
        while (mcu_wait) begin
            if (cycles == WAIT_LIMIT) begin
                $display("mcu_wait stayed high for %0d cycles (entry %0d)", cycles, entry_idx);
                stop_run();
            end
            next_cycle();
            cycles++;
        end
        // request lines already dropped by now
        check_flag("av_read", av_read, 1'b0);
        check_flag("av_write", av_write, 1'b0);
    endtask

    task automatic do_load(input ioreg_pkg::reg_num_t rnum, input ioreg_pkg::word_t data);
        reg_addr = rnum;
        reg_wdata = data;
        reg_load = 1'b1;
        next_cycle();
        reg_load = 1'b0;
        // address halves the bus should present
        if (rnum == ioreg_pkg::REG_AV_AD_HI) begin
            exp_ad_hi = data;
        end
        if (rnum == ioreg_pkg::REG_AV_AD_LO) begin
            exp_ad_lo = data;
        end
        // write data load kicks off a bus write
        if (rnum == ioreg_pkg::REG_AV_WRITE_DATA) begin
            check_flag("mcu_wait", mcu_wait, 1'b1);
            check_flag("av_write", av_write, 1'b1);
            check_bus_address();
            wait_bus_idle();
        end
    endtask

    task automatic do_read(input ioreg_pkg::reg_num_t rnum, input ioreg_pkg::word_t exp);
        reg_addr = rnum;
        reg_read = 1'b1;
        #SETTLE;
        // value being consumed
        check_value("reg_rdata", reg_rdata, exp);
        next_cycle();
        reg_read = 1'b0;
        // consuming the write data register starts a bus read
        if (rnum == ioreg_pkg::REG_AV_WRITE_DATA) begin
            check_flag("mcu_wait", mcu_wait, 1'b1);
            check_flag("av_read", av_read, 1'b1);
            check_bus_address();
            wait_bus_idle();
        end
    endtask

    task automatic do_peek(input ioreg_pkg::reg_num_t rnum, input ioreg_pkg::word_t exp);
        reg_addr = rnum;
        #SETTLE;
        check_value("reg_rdata", reg_rdata, exp);
        next_cycle();
    endtask

    // slave model acting 1 ns after each edge
    initial begin
        av_waitrequest = 1'b1;
        av_readdata = '0;
        rng_state = 32'd49;
        stall_left = 0;
        in_txn = 1'b0;
        accept_pending = 1'b0;
        acc_write = 1'b0;
        acc_idx = '0;
        acc_data = '0;
        // fill word built from the full index
        for (int i = 0; i < 256; i++) begin
            slave_mem[i] = {8'(i), ~8'(i)};
        end
        forever begin
            @(posedge sysclk);
            #1;
            // request was taken at the edge just passed
            if (accept_pending) begin
                if (acc_write) begin
                    slave_mem[acc_idx] = acc_data;
                end
                accept_pending = 1'b0;
                av_waitrequest = 1'b1;
            end
            if (!in_txn && (av_read || av_write)) begin
                in_txn = 1'b1;
                rng_state = xorshift32(rng_state);
                // 0 to 3 stall cycles
                stall_left = int'(rng_state[1:0]);
            end
            if (in_txn) begin
                if (stall_left == 0) begin
                    av_waitrequest = 1'b0;
                    accept_pending = 1'b1;
                    in_txn = 1'b0;
                    acc_write = av_write;
                    acc_idx = av_address[7:0];
                    acc_data = av_writedata;
                    av_readdata = slave_mem[av_address[7:0]];
                end else begin
                    stall_left--;
                end
            end
        end
    end

    initial begin
        logic [31:0] entry;
        logic [3:0] op;
        ioreg_pkg::reg_num_t rnum;
        ioreg_pkg::word_t data;
        int num_ops;
        sysclk = 1'b0;
        rst = 1'b1;
        reg_addr = '0;
        reg_wdata = '0;
        reg_load = 1'b0;
        reg_read = 1'b0;
        keys = 2'b00;
        entry_idx = -1;
        exp_ad_hi = '0;
        exp_ad_lo = '0;
        num_ops = 0;
        for (int n = 0; n < STIM_DEPTH; n++) begin
            stim[n] = '0;
        end
        $readmemh("tb/io_stimulus.txt", stim);

        // reset over 5 rising edges
        repeat (5) @(posedge sysclk);
        #DRIVE_DELAY;
        rst = 1'b0;

        // everything clear out of reset
        check_flag("mcu_wait", mcu_wait, 1'b0);
        check_flag("av_read", av_read, 1'b0);
        check_flag("av_write", av_write, 1'b0);
        check_value("leds", {8'h00, leds}, 16'h0000);
        check_value("anmux_ctrl", {12'h000, anmux_ctrl}, 16'h0000);
        for (int r = 0; r < ioreg_pkg::NUM_REGS; r++) begin
            do_peek(5'(r), 16'h0000);
        end

        for (int n = 0; n < STIM_DEPTH; n++) begin
            entry = stim[n];
            op = entry[31:28];
            if (op == 4'h0) begin
                break;
            end
            entry_idx = n;
            rnum = entry[24:20];
            data = entry[19:4];
            keys = entry[1:0];
            num_ops++;
            case (op)
                4'h1: do_load(rnum, data);
                4'h2: do_read(rnum, data);
                4'h3: do_peek(rnum, data);
                4'h4: begin
                    // low byte leds and next nibble anmux
                    check_value("leds", {8'h00, leds}, {8'h00, data[7:0]});
                    check_value("anmux_ctrl", {12'h000, anmux_ctrl}, {12'h000, data[11:8]});
                end
                4'h5: check_value($sformatf("slave_mem[0x%h]", entry[27:20]),
                                  slave_mem[entry[27:20]], data);
                default: begin
                    $display("unknown operation %0h in stimulus entry %0d", op, n);
                    stop_run();
                end
            endcase
        end

        if (num_ops == 0) begin
            $display("no operations were read from the stimulus file");
            stop_run();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/av_master_bridge.sv ====
`default_nettype none

module av_master_bridge (
    input wire sysclk,
    input wire rst,
    input wire [ioreg_pkg::NUM_REGS-1:0] load_sel,
    input wire [ioreg_pkg::NUM_REGS-1:0] read_sel,
    input wire ioreg_pkg::word_t reg_wdata,
    output ioreg_pkg::word_t ad_hi,
    output ioreg_pkg::word_t ad_lo,
    output ioreg_pkg::word_t write_data,
    output ioreg_pkg::word_t read_data,
    output logic mcu_wait,
    output avbus_pkg::av_addr_t av_address,
    output logic av_read,
    output logic av_write,
    output avbus_pkg::av_data_t av_writedata,
    input wire avbus_pkg::av_data_t av_readdata,
    input wire av_waitrequest
);

    // high for the cycle after a read completes
    logic read_tail;
    logic busy;
    logic start_write;
    logic start_read;
    logic write_done;
    logic read_done;

    // a transaction is in flight or in its capture cycle
    assign busy = av_write | av_read | read_tail;
    assign mcu_wait = busy;

    // loading write data starts a write
    assign start_write = load_sel[ioreg_pkg::REG_AV_WRITE_DATA] & ~busy;
    // consuming the write data register starts a read
    // write wins if both arrive together
    assign start_read = read_sel[ioreg_pkg::REG_AV_WRITE_DATA] & ~busy & ~start_write;

    // slave accepts at the first edge without waitrequest
    assign write_done = av_write & ~av_waitrequest;
    assign read_done = av_read & ~av_waitrequest;

    // address and data registers
    // frozen while busy so the bus request stays steady
    always_ff @(posedge sysclk) begin
        if (rst) begin
            ad_hi <= '0;
            ad_lo <= '0;
            write_data <= '0;
        end else if (!busy) begin
            if (load_sel[ioreg_pkg::REG_AV_AD_HI]) begin
                ad_hi <= reg_wdata;
            end
            if (load_sel[ioreg_pkg::REG_AV_AD_LO]) begin
                ad_lo <= reg_wdata;
            end
            if (load_sel[ioreg_pkg::REG_AV_WRITE_DATA]) begin
                write_data <= reg_wdata;
            end
        end
    end

    // read data capture on the accepting edge
    always_ff @(posedge sysclk) begin
        if (rst) begin
            read_data <= '0;
        end else if (read_done) begin
            read_data <= av_readdata;
        end
    end

    // transaction sequencer
    always_ff @(posedge sysclk) begin
        if (rst) begin
            av_write <= 1'b0;
            av_read <= 1'b0;
            read_tail <= 1'b0;
        end else begin
            // extra wait cycle so the core sees the captured word
            read_tail <= read_done;
            if (write_done) begin
                av_write <= 1'b0;
            end else if (start_write) begin
                av_write <= 1'b1;
            end
            if (read_done) begin
                av_read <= 1'b0;
            end else if (start_read) begin
                av_read <= 1'b1;
            end
        end
    end

    // bus side views of the registers
    assign av_address = {ad_hi, ad_lo};
    assign av_writedata = write_data;

endmodule

`default_nettype wire

// ==== verilog/avbus_pkg.sv ====
`default_nettype none

package avbus_pkg;

    // byte address as seen by the slave system
    localparam int AV_ADDR_W = 32;
    typedef logic [AV_ADDR_W-1:0] av_addr_t;

    // one bus beat carries one core word
    localparam int AV_DATA_W = 16;
    typedef logic [AV_DATA_W-1:0] av_data_t;

endpackage

`default_nettype wire

// ==== verilog/gp_reg_bank.sv ====
`default_nettype none

module gp_reg_bank #(
    parameter int GP_COUNT = 8
) (
    input wire sysclk,
    input wire rst,
    input wire [ioreg_pkg::NUM_REGS-1:0] load_sel,
    input wire ioreg_pkg::word_t reg_wdata,
    output ioreg_pkg::word_t [GP_COUNT-1:0] gp_values,
    output ioreg_pkg::word_t leds_value,
    output ioreg_pkg::word_t anmux_value
);

    // general purpose storage
    ioreg_pkg::word_t [GP_COUNT-1:0] gp_q;
    // board output registers
    ioreg_pkg::word_t leds_q;
    ioreg_pkg::word_t anmux_q;

    // one load per register per cycle
    // gp slot i answers to register number i
    always_ff @(posedge sysclk) begin
        if (rst) begin
            gp_q <= '0;
        end else begin
            for (int i = 0; i < GP_COUNT; i++) begin
                if (load_sel[i]) begin
                    gp_q[i] <= reg_wdata;
                end
            end
        end
    end

    // led register, full word kept
    // only the low byte reaches the pins
    always_ff @(posedge sysclk) begin
        if (rst) begin
            leds_q <= '0;
        end else if (load_sel[ioreg_pkg::REG_LEDS]) begin
            leds_q <= reg_wdata;
        end
    end

    // analog mux control, low nibble drives the dg408
    always_ff @(posedge sysclk) begin
        if (rst) begin
            anmux_q <= '0;
        end else if (load_sel[ioreg_pkg::REG_ANMUX]) begin
            anmux_q <= reg_wdata;
        end
    end

    assign gp_values = gp_q;
    assign leds_value = leds_q;
    assign anmux_value = anmux_q;

endmodule

`default_nettype wire

// ==== verilog/io_subsystem_top.sv ====
`default_nettype none

module io_subsystem_top #(
    parameter int GP_COUNT = 8,
    parameter int STACK_DEPTH = 32
) (
    input wire sysclk,
    input wire rst,
    // core register port
    input wire ioreg_pkg::reg_num_t reg_addr,
    input wire ioreg_pkg::word_t reg_wdata,
    input wire reg_load,
    input wire reg_read,
    output ioreg_pkg::word_t reg_rdata,
    output logic mcu_wait,
    // board pins
    input wire [1:0] keys,
    output logic [7:0] leds,
    output logic [3:0] anmux_ctrl,
    // avalon master
    output avbus_pkg::av_addr_t av_address,
    output logic av_read,
    output logic av_write,
    output avbus_pkg::av_data_t av_writedata,
    input wire avbus_pkg::av_data_t av_readdata,
    input wire av_waitrequest
);

    logic [ioreg_pkg::NUM_REGS-1:0] load_sel;
    logic [ioreg_pkg::NUM_REGS-1:0] read_sel;
    ioreg_pkg::word_t [GP_COUNT-1:0] gp_values;
    ioreg_pkg::word_t leds_value;
    ioreg_pkg::word_t anmux_value;
    ioreg_pkg::word_t stack_top;
    ioreg_pkg::word_t ad_hi;
    ioreg_pkg::word_t ad_lo;
    ioreg_pkg::word_t write_data;
    ioreg_pkg::word_t read_data;

    ioreg_decode #(.GP_COUNT(GP_COUNT)) u_decode (
        .reg_addr(reg_addr), .reg_load(reg_load), .reg_read(reg_read),
        .load_sel(load_sel), .read_sel(read_sel)
    );

    gp_reg_bank #(.GP_COUNT(GP_COUNT)) u_gp_bank (
        .sysclk(sysclk), .rst(rst), .load_sel(load_sel), .reg_wdata(reg_wdata),
        .gp_values(gp_values), .leds_value(leds_value), .anmux_value(anmux_value)
    );

    // load of the stack register pushes, consuming read pops
    return_stack #(.STACK_DEPTH(STACK_DEPTH)) u_rstk (
        .sysclk(sysclk), .rst(rst),
        .push(load_sel[ioreg_pkg::REG_RSTK]), .pop(read_sel[ioreg_pkg::REG_RSTK]),
        .push_data(reg_wdata), .top(stack_top)
    );

    av_master_bridge u_bridge (
        .sysclk(sysclk), .rst(rst), .load_sel(load_sel), .read_sel(read_sel),
        .reg_wdata(reg_wdata), .ad_hi(ad_hi), .ad_lo(ad_lo),
        .write_data(write_data), .read_data(read_data), .mcu_wait(mcu_wait),
        .av_address(av_address), .av_read(av_read), .av_write(av_write),
        .av_writedata(av_writedata), .av_readdata(av_readdata),
        .av_waitrequest(av_waitrequest)
    );

    ioreg_readback #(.GP_COUNT(GP_COUNT)) u_readback (
        .reg_addr(reg_addr), .gp_values(gp_values), .stack_top(stack_top),
        .leds_value(leds_value), .keys(keys), .anmux_value(anmux_value),
        .ad_hi(ad_hi), .ad_lo(ad_lo), .write_data(write_data),
        .read_data(read_data), .reg_rdata(reg_rdata)
    );

    // low bits reach the pins
    assign leds = leds_value[7:0];
    assign anmux_ctrl = anmux_value[3:0];

endmodule

`default_nettype wire

// ==== verilog/ioreg_decode.sv ====
`default_nettype none

module ioreg_decode #(
    parameter int GP_COUNT = 8
) (
    input wire ioreg_pkg::reg_num_t reg_addr,
    input wire reg_load,
    input wire reg_read,
    output logic [ioreg_pkg::NUM_REGS-1:0] load_sel,
    output logic [ioreg_pkg::NUM_REGS-1:0] read_sel
);

    // map of implemented numbers
    // writable drops the read-only registers
    function automatic logic [ioreg_pkg::NUM_REGS-1:0] map_mask(input logic writable);
        logic [ioreg_pkg::NUM_REGS-1:0] mask;
        mask = '0;
        for (int i = 0; i < ioreg_pkg::NUM_REGS; i++) begin
            // populated general purpose slots
            if (i < GP_COUNT) begin
                mask[i] = 1'b1;
            end
            // fixed block from stack top to bus read data
            if (i >= int'(ioreg_pkg::REG_FIXED_FIRST) &&
                i <= int'(ioreg_pkg::REG_FIXED_LAST)) begin
                mask[i] = 1'b1;
            end
        end
        if (writable) begin
            mask[ioreg_pkg::REG_KEYS] = 1'b0;
            mask[ioreg_pkg::REG_AV_READ_DATA] = 1'b0;
        end
        return mask;
    endfunction

    localparam logic [ioreg_pkg::NUM_REGS-1:0] LOAD_MASK = map_mask(1'b1);
    localparam logic [ioreg_pkg::NUM_REGS-1:0] READ_MASK = map_mask(1'b0);

    logic [ioreg_pkg::NUM_REGS-1:0] addr_onehot;

    // plain binary to one-hot
    always_comb begin
        addr_onehot = '0;
        addr_onehot[reg_addr] = 1'b1;
    end

    // strobes gate the selects, nothing selected between strobes
    assign load_sel = reg_load ? (addr_onehot & LOAD_MASK) : '0;
    assign read_sel = reg_read ? (addr_onehot & READ_MASK) : '0;

endmodule

`default_nettype wire

// ==== verilog/ioreg_pkg.sv ====
`default_nettype none

package ioreg_pkg;

    // core register word
    localparam int WORD_W = 16;
    typedef logic [WORD_W-1:0] word_t;

    // flat register number space
    localparam int REG_NUM_W = 5;
    typedef logic [REG_NUM_W-1:0] reg_num_t;
    localparam int NUM_REGS = 32;

    // general purpose registers sit at the bottom of the map
    // numbers 0 up to GP_COUNT-1, never more than GP_MAX of them
    localparam int GP_MAX = 16;

    // hardware return stack top
    localparam reg_num_t REG_RSTK = 5'd16;

    // board outputs
    localparam reg_num_t REG_LEDS = 5'd17;
    // read-only key status
    localparam reg_num_t REG_KEYS = 5'd18;
    // dg408 analog mux, en a2 a1 a0
    localparam reg_num_t REG_ANMUX = 5'd19;

    // avalon address halves
    localparam reg_num_t REG_AV_AD_HI = 5'd20;
    localparam reg_num_t REG_AV_AD_LO = 5'd21;
    // write data, loading it starts a write
    // a consuming read of it starts a read
    localparam reg_num_t REG_AV_WRITE_DATA = 5'd22;
    // last word captured from the bus, read-only
    localparam reg_num_t REG_AV_READ_DATA = 5'd23;

    // first and last numbers of the fixed register block
    localparam reg_num_t REG_FIXED_FIRST = REG_RSTK;
    localparam reg_num_t REG_FIXED_LAST = REG_AV_READ_DATA;

endpackage

`default_nettype wire

// ==== verilog/ioreg_readback.sv ====
`default_nettype none

module ioreg_readback #(
    parameter int GP_COUNT = 8
) (
    input wire ioreg_pkg::reg_num_t reg_addr,
    input wire ioreg_pkg::word_t [GP_COUNT-1:0] gp_values,
    input wire ioreg_pkg::word_t stack_top,
    input wire ioreg_pkg::word_t leds_value,
    input wire [1:0] keys,
    input wire ioreg_pkg::word_t anmux_value,
    input wire ioreg_pkg::word_t ad_hi,
    input wire ioreg_pkg::word_t ad_lo,
    input wire ioreg_pkg::word_t write_data,
    input wire ioreg_pkg::word_t read_data,
    output ioreg_pkg::word_t reg_rdata
);

    localparam int GP_IDX_W = $clog2(ioreg_pkg::GP_MAX);

    // gp window padded to the full slot range
    // unpopulated slots hold zero
    ioreg_pkg::word_t [ioreg_pkg::GP_MAX-1:0] gp_padded;

    always_comb begin
        gp_padded = '0;
        gp_padded[GP_COUNT-1:0] = gp_values;
    end

    // addressed value, purely combinational
    always_comb begin
        case (reg_addr)
            ioreg_pkg::REG_RSTK: reg_rdata = stack_top;
            ioreg_pkg::REG_LEDS: reg_rdata = leds_value;
            // key pins zero-extended
            ioreg_pkg::REG_KEYS: reg_rdata = {{(ioreg_pkg::WORD_W-2){1'b0}}, keys};
            ioreg_pkg::REG_ANMUX: reg_rdata = anmux_value;
            ioreg_pkg::REG_AV_AD_HI: reg_rdata = ad_hi;
            ioreg_pkg::REG_AV_AD_LO: reg_rdata = ad_lo;
            ioreg_pkg::REG_AV_WRITE_DATA: reg_rdata = write_data;
            ioreg_pkg::REG_AV_READ_DATA: reg_rdata = read_data;
            default: begin
                // gp window at the bottom, zero above the fixed block
                if (int'(reg_addr) < ioreg_pkg::GP_MAX) begin
                    reg_rdata = gp_padded[reg_addr[GP_IDX_W-1:0]];
                end else begin
                    reg_rdata = '0;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/return_stack.sv ====
`default_nettype none

module return_stack #(
    parameter int STACK_DEPTH = 32
) (
    input wire sysclk,
    input wire rst,
    input wire push,
    input wire pop,
    input wire ioreg_pkg::word_t push_data,
    output ioreg_pkg::word_t top
);

    localparam int PTR_W = $clog2(STACK_DEPTH);

    // entry storage
    ioreg_pkg::word_t mem [STACK_DEPTH];
    // per slot occupancy, an empty slot reads zero
    logic [STACK_DEPTH-1:0] valid;
    // points at the current top, wraps around
    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] ptr_up;
    logic [PTR_W-1:0] ptr_down;
    logic [PTR_W-1:0] wr_ptr;

    assign ptr_up = ptr + 1'b1;
    assign ptr_down = ptr - 1'b1;

    // push alone goes above the top
    // push with pop overwrites the top in place
    assign wr_ptr = pop ? ptr : ptr_up;

    always_ff @(posedge sysclk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointer and occupancy
    always_ff @(posedge sysclk) begin
        if (rst) begin
            ptr <= '0;
            valid <= '0;
        end else if (push && pop) begin
            valid[ptr] <= 1'b1;
        end else if (push) begin
            // wrapping push overwrites the oldest entry
            valid[ptr_up] <= 1'b1;
            ptr <= ptr_up;
        end else if (pop) begin
            // vacated slot goes empty
            valid[ptr] <= 1'b0;
            ptr <= ptr_down;
        end
    end

    // top of stack for readback
    assign top = valid[ptr] ? mem[ptr] : '0;

endmodule

`default_nettype wire
